/* Bender.yml */
package:
  name: pipe_top

sources:
  - cpu_pkg.sv
  - insn_decode.sv
  - reg_file.sv
  - alu_execute.sv
  - writeback_unit.sv
  - pipe_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_pipe_top.sv

/* alu_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      issue_valid,
   input  wire  cpu_pkg::dec_op_t   issue_op,
   output logic                     issue_ready,
   output cpu_pkg::reg_idx_t        rd_a,
   output cpu_pkg::reg_idx_t        rd_b,
   input  wire  cpu_pkg::word_t     rd_a_data,
   input  wire  cpu_pkg::word_t     rd_b_data,
   output logic                     ex_valid,
   output cpu_pkg::ex_res_t         ex_res,
   input  wire                      wb_ready
);

   cpu_pkg::word_t   opnd_a;
   cpu_pkg::word_t   opnd_b;
   cpu_pkg::ex_res_t res_next;
   logic             issue_fire;

   // interlock needs execute and writeback both empty
   assign issue_ready = !ex_valid && wb_ready;
   assign issue_fire  = issue_valid && issue_ready;

   assign rd_a   = issue_op.dst;
   assign rd_b   = issue_op.src;
   assign opnd_a = rd_a_data;
   assign opnd_b = issue_op.use_imm ? cpu_pkg::word_t'(issue_op.imm) : rd_b_data;

   always_comb begin
      res_next            = '0;
      res_next.op         = issue_op.op;
      res_next.dst        = issue_op.dst;
      res_next.src        = issue_op.src;
      res_next.store_addr = issue_op.imm;
      case (issue_op.op)
         cpu_pkg::op_add:   res_next.result = opnd_a + opnd_b;
         cpu_pkg::op_sub:   res_next.result = opnd_a - opnd_b;
         cpu_pkg::op_and:   res_next.result = opnd_a & opnd_b;
         cpu_pkg::op_or:    res_next.result = opnd_a | opnd_b;
         cpu_pkg::op_xor:   res_next.result = opnd_a ^ opnd_b;
         cpu_pkg::op_mov:   res_next.result = opnd_b;
         cpu_pkg::op_xchg: begin
            res_next.result   = opnd_b;
            res_next.result_2 = opnd_a;
         end
         // store data is the dst register
         cpu_pkg::op_store: res_next.result = opnd_a;
         default:           res_next.result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else if (issue_fire) begin
         ex_valid <= 1'b1;
      end else if (ex_valid && wb_ready) begin
         ex_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_fire) begin
         ex_res <= res_next;
      end
   end

   // decode never hands over codes 8..15
   a_legal_op: assert property (
      @(posedge clk) disable iff (!rst_n)
      issue_fire |-> (issue_op.op <= cpu_pkg::op_store)
   ) else $error("illegal op issued: %0d", issue_op.op);

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   localparam int word_w = 32;

   typedef logic [word_w-1:0] word_t;
   typedef logic [2:0]        reg_idx_t;
   typedef logic [15:0]       imm_t;

   typedef enum logic [3:0] {
      op_add   = 4'd0,
      op_sub   = 4'd1,
      op_and   = 4'd2,
      op_or    = 4'd3,
      op_xor   = 4'd4,
      op_mov   = 4'd5,
      op_xchg  = 4'd6,
      op_store = 4'd7
   } alu_op_e;

   // fmt = 0
   typedef struct packed {
      alu_op_e     op;
      logic        fmt;
      reg_idx_t    dst;
      reg_idx_t    src;
      logic [20:0] unused;
   } reg_form_t;

   // fmt = 1
   typedef struct packed {
      alu_op_e    op;
      logic       fmt;
      reg_idx_t   dst;
      logic [7:0] unused;
      imm_t       imm;
   } imm_form_t;

   // two views of one instruction word
   typedef union packed {
      reg_form_t reg_form;
      imm_form_t imm_form;
   } instr_t;

   // decode to execute
   typedef struct packed {
      alu_op_e  op;
      reg_idx_t dst;
      reg_idx_t src;
      logic     use_imm;
      imm_t     imm;
   } dec_op_t;

   // execute to writeback
   typedef struct packed {
      alu_op_e  op;
      reg_idx_t dst;
      reg_idx_t src;
      word_t    result;
      word_t    result_2;
      imm_t     store_addr;
   } ex_res_t;

endpackage

`default_nettype wire

/* insn_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module insn_decode (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    in_valid,
   input  wire  cpu_pkg::instr_t  in_instr,
   output logic                   in_ready,
   output logic                   issue_valid,
   output cpu_pkg::dec_op_t       issue_op,
   input  wire                    issue_ready
);

   logic            hold_valid;
   cpu_pkg::instr_t hold_instr;
   logic            accept;
   logic            leave;

   assign leave    = hold_valid && issue_ready;
   assign in_ready = !hold_valid || issue_ready;
   assign accept   = in_valid && in_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hold_valid <= 1'b0;
      end else if (accept) begin
         hold_valid <= 1'b1;
      end else if (leave) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         hold_instr <= in_instr;
      end
   end

   assign issue_valid = hold_valid;

   // op and dst sit at the same bits in both views
   always_comb begin
      issue_op         = '0;
      issue_op.op      = hold_instr.reg_form.op;
      issue_op.dst     = hold_instr.reg_form.dst;
      issue_op.use_imm = hold_instr.imm_form.fmt;
      // view picked by fmt
      if (hold_instr.imm_form.fmt) begin
         issue_op.imm = hold_instr.imm_form.imm;
      end else begin
         issue_op.src = hold_instr.reg_form.src;
      end
   end

   // upstream must hold the word while stalled
   a_in_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      in_valid && !in_ready |=> $stable(in_instr)
   ) else $error("in_instr changed while waiting for in_ready");

endmodule

`default_nettype wire

/* pipe_testdata.mem */
// each entry is 16 hex digits: upper 8 the instruction word,
// lower 8 the expected store data (zero and ignored on non-store lines)
// stores of r0..r7 straight after reset
7800F01000000000
7900F01100000000
7A00F01200000000
7B00F01300000000
7C00F01400000000
7D00F01500000000
7E00F01600000000
7F00F01700000000
// immediate moves, then register-form alu ops
5900123400000000
5A0000FF00000000
5B00F0F000000000
7900C02000001234
7A00C021000000FF
7B00C0220000F0F0
0140000000000000
7900C02300001333
1340000000000000
7B00C0240000EFF1
2320000000000000
7B00C02500000331
3220000000000000
7A00C026000013FF
4140000000000000
7900C027000000CC
5440000000000000
7C00C028000013FF
// immediate-form alu ops
0C00000100000000
7C00C02900001400
1D00000100000000
7D00C02AFFFFFFFF
2D00A5A500000000
7D00C02B0000A5A5
3D005A0000000000
7D00C02C0000FFA5
4D0000FF00000000
7D00C02D0000FF5A
// xchg r4, r5
64A0000000000000
7C00C02E0000FF5A
7D00C02F00001400
// dependent chain on r6 and r7
5E00001000000000
06C0000000000000
06C0000000000000
17C0000000000000
0E00000300000000
7E00C03000000043
7F00C031FFFFFFC0

/* pipe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_top #(
   parameter int addr_w = 16
) (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     in_valid,
   input  wire  cpu_pkg::instr_t   in_instr,
   output logic                    in_ready,
   output logic                    wmem_valid,
   input  wire                     wmem_ready,
   output logic [addr_w-1:0]       wmem_address,
   output cpu_pkg::word_t          wmem_wr_data
);

   // decode to execute
   logic              issue_valid;
   logic              issue_ready;
   cpu_pkg::dec_op_t  issue_op;

   // execute to writeback
   logic              ex_valid;
   logic              wb_ready;
   cpu_pkg::ex_res_t  ex_res;

   // register file
   cpu_pkg::reg_idx_t rd_a;
   cpu_pkg::reg_idx_t rd_b;
   cpu_pkg::word_t    rd_a_data;
   cpu_pkg::word_t    rd_b_data;
   logic              wr_en;
   cpu_pkg::reg_idx_t wr_idx;
   cpu_pkg::word_t    wr_data;
   logic              wr2_en;
   cpu_pkg::reg_idx_t wr2_idx;
   cpu_pkg::word_t    wr2_data;

   insn_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_instr    (in_instr),
      .in_ready    (in_ready),
      .issue_valid (issue_valid),
      .issue_op    (issue_op),
      .issue_ready (issue_ready)
   );

   reg_file u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_a      (rd_a),
      .rd_a_data (rd_a_data),
      .rd_b      (rd_b),
      .rd_b_data (rd_b_data),
      .wr_en     (wr_en),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data),
      .wr2_en    (wr2_en),
      .wr2_idx   (wr2_idx),
      .wr2_data  (wr2_data)
   );

   alu_execute u_execute (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_op    (issue_op),
      .issue_ready (issue_ready),
      .rd_a        (rd_a),
      .rd_b        (rd_b),
      .rd_a_data   (rd_a_data),
      .rd_b_data   (rd_b_data),
      .ex_valid    (ex_valid),
      .ex_res      (ex_res),
      .wb_ready    (wb_ready)
   );

   writeback_unit #(
      .addr_w (addr_w)
   ) u_writeback (
      .clk          (clk),
      .rst_n        (rst_n),
      .ex_valid     (ex_valid),
      .ex_res       (ex_res),
      .wb_ready     (wb_ready),
      .wr_en        (wr_en),
      .wr_idx       (wr_idx),
      .wr_data      (wr_data),
      .wr2_en       (wr2_en),
      .wr2_idx      (wr2_idx),
      .wr2_data     (wr2_data),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_address (wmem_address),
      .wmem_wr_data (wmem_wr_data)
   );

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire  cpu_pkg::reg_idx_t  rd_a,
   output cpu_pkg::word_t           rd_a_data,
   input  wire  cpu_pkg::reg_idx_t  rd_b,
   output cpu_pkg::word_t           rd_b_data,
   input  wire                      wr_en,
   input  wire  cpu_pkg::reg_idx_t  wr_idx,
   input  wire  cpu_pkg::word_t     wr_data,
   input  wire                      wr2_en,
   input  wire  cpu_pkg::reg_idx_t  wr2_idx,
   input  wire  cpu_pkg::word_t     wr2_data
);

   cpu_pkg::word_t regs [8];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (wr_en) begin
            regs[wr_idx] <= wr_data;
         end
         // second port last, so it wins on a clash
         if (wr2_en) begin
            regs[wr2_idx] <= wr2_data;
         end
      end
   end

   assign rd_a_data = regs[rd_a];
   assign rd_b_data = regs[rd_b];

endmodule

`default_nettype wire

/* sources.f */
cpu_pkg.sv
insn_decode.sv
reg_file.sv
alu_execute.sv
writeback_unit.sv
pipe_top.sv
tb_clock_gen.sv
tb_pipe_top.sv

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
   parameter int period       = 10,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // reset released just after a rising edge
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* tb_pipe_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_top;

   localparam int addr_w  = 12;
   localparam int n_lines = 46;
   localparam int limit   = n_lines * 50 + 200;

   wire               clk;
   wire               rst_n;
   logic              in_valid   = 1'b0;
   cpu_pkg::instr_t   in_instr   = '0;
   logic              wmem_ready = 1'b0;
   wire               in_ready;
   wire               wmem_valid;
   wire [addr_w-1:0]  wmem_address;
   cpu_pkg::word_t    wmem_wr_data;

   logic [63:0]       prog [n_lines];
   cpu_pkg::word_t    exp_data_q [$];
   logic [addr_w-1:0] exp_addr_q [$];
   int                n_stores    = 0;
   int                store_count = 0;
   logic [31:0]       gap_lfsr    = 32'hfec7;
   logic [31:0]       ready_lfsr  = 32'hfec7;
   logic              waiting     = 1'b0;
   cpu_pkg::word_t    held_data;
   logic [addr_w-1:0] held_addr;

   tb_clock_gen #(.period(10), .reset_cycles(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

   pipe_top #(.addr_w(addr_w)) uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid     (in_valid),
      .in_instr     (in_instr),
      .in_ready     (in_ready),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_address (wmem_address),
      .wmem_wr_data (wmem_wr_data)
   );

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_store_data(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
                                   input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_store_addr(input logic [addr_w-1:0] got,
                                   input logic [addr_w-1:0] exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // random idle gap, then hold the word until in_ready
   task automatic send_instr(input cpu_pkg::instr_t instr);
      gap_lfsr = lfsr_next(gap_lfsr);
      while (gap_lfsr[0]) begin
         in_valid <= 1'b0;
         @(posedge clk);
         gap_lfsr = lfsr_next(gap_lfsr);
      end
      in_valid <= 1'b1;
      in_instr <= instr;
      do begin
         @(posedge clk);
      end while (!in_ready);
   endtask

   // memory side back-pressure
   always @(posedge clk) begin
      if (!rst_n) begin
         wmem_ready <= 1'b0;
      end else begin
         ready_lfsr = lfsr_next(ready_lfsr);
         wmem_ready <= ready_lfsr[0];
      end
   end

   // store monitor sees the values from just before the edge
   always @(posedge clk) begin
      if (rst_n) begin
         if (waiting && !wmem_valid) begin
            $display("store withdrawn at %0t ns before wmem_ready was seen", $time);
            abort_run();
         end else if (wmem_valid && wmem_ready && exp_data_q.size() == 0) begin
            $display("extra store at %0t ns, more stores than store lines", $time);
            abort_run();
         end else begin
            if (waiting) begin
               check_store_addr(wmem_address, held_addr, "address held during stall");
               check_store_data(wmem_wr_data, held_data, "data held during stall");
            end
            if (wmem_valid && wmem_ready) begin
               check_store_addr(wmem_address, exp_addr_q.pop_front(), "store address");
               check_store_data(wmem_wr_data, exp_data_q.pop_front(), "store data");
               store_count++;
            end
            waiting   = wmem_valid && !wmem_ready;
            held_addr = wmem_address;
            held_data = wmem_wr_data;
         end
      end
   end

   initial begin
      cpu_pkg::instr_t instr;
      $readmemh("pipe_testdata.mem", prog);
      if ($isunknown(prog[n_lines-1])) begin
         $display("pipe_testdata.mem is missing or has fewer than %0d lines", n_lines);
         abort_run();
      end else begin
         // expected address is imm cut to addr_w
         for (int i = 0; i < n_lines; i++) begin
            instr = prog[i][63:32];
            if (instr.imm_form.op == cpu_pkg::op_store) begin
               exp_data_q.push_back(prog[i][31:0]);
               exp_addr_q.push_back(instr.imm_form.imm[addr_w-1:0]);
            end
         end
         n_stores = exp_data_q.size();
         wait (rst_n === 1'b1);
         @(posedge clk);
         for (int i = 0; i < n_lines; i++) begin
            send_instr(prog[i][63:32]);
         end
         in_valid <= 1'b0;
         wait (store_count == n_stores);
         @(posedge clk);
         // the last line is a store, so the pipeline must be empty now
         if (!wmem_valid && in_ready) begin
            $display("all tests passed");
            $finish;
         end else begin
            $display("[FAIL] %0t ns: pipeline busy after the last store, wmem_valid %b in_ready %b",
                     $time, wmem_valid, in_ready);
            abort_run();
         end
      end
   end

   // watchdog
   initial begin
      repeat (limit) @(posedge clk);
      $display("timeout after %0d cycles, the pipeline stopped delivering stores", limit);
      abort_run();
   end

endmodule

`default_nettype wire

/* writeback_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_unit #(
   parameter int addr_w = 16
) (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      ex_valid,
   input  wire  cpu_pkg::ex_res_t   ex_res,
   output logic                     wb_ready,
   output logic                     wr_en,
   output cpu_pkg::reg_idx_t        wr_idx,
   output cpu_pkg::word_t           wr_data,
   output logic                     wr2_en,
   output cpu_pkg::reg_idx_t        wr2_idx,
   output cpu_pkg::word_t           wr2_data,
   output logic                     wmem_valid,
   input  wire                      wmem_ready,
   output logic [addr_w-1:0]        wmem_address,
   output cpu_pkg::word_t           wmem_wr_data
);

   logic             wb_full;
   cpu_pkg::ex_res_t wb_res;
   logic             is_store;
   logic             is_xchg;
   logic             retire;

   assign is_store = (wb_res.op == cpu_pkg::op_store);
   assign is_xchg  = (wb_res.op == cpu_pkg::op_xchg);

   assign wb_ready = !wb_full;
   // stores wait on the memory port
   assign retire   = wb_full && (!is_store || wmem_ready);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_full <= 1'b0;
      end else if (ex_valid && wb_ready) begin
         wb_full <= 1'b1;
      end else if (retire) begin
         wb_full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid && wb_ready) begin
         wb_res <= ex_res;
      end
   end

   // register writes land on the retire edge
   assign wr_en    = wb_full && !is_store;
   assign wr_idx   = wb_res.dst;
   assign wr_data  = wb_res.result;

   // xchg puts the old dst into src
   assign wr2_en   = wb_full && is_xchg;
   assign wr2_idx  = wb_res.src;
   assign wr2_data = wb_res.result_2;

   assign wmem_valid   = wb_full && is_store;
   assign wmem_address = addr_w'(wb_res.store_addr);
   assign wmem_wr_data = wb_res.result;

   a_wmem_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      wmem_valid && !wmem_ready |=>
         wmem_valid && $stable(wmem_address) && $stable(wmem_wr_data)
   ) else $error("wmem payload changed while waiting for wmem_ready");

endmodule

`default_nettype wire
